// File: logic/link_pkg.sv
package link_pkg;

  // width of one serial word on the link
  // the message words at the top level default to the same width
  localparam int word_width_c = 16;

  // default number of words in one message, header included
  localparam int max_words_c = 8;

  // field widths of the header word, which add up to one serial word
  localparam int opcode_width_c = 2;
  localparam int count_width_c  = 6;
  localparam int tag_width_c    = 8;

  // message kinds carried in the top bits of word 0
  // the opcode alone fixes the length, except for op_write
  typedef enum logic [opcode_width_c-1:0] {
    // header only, no payload words follow
    op_nop   = 2'd0,
    // header plus one address word
    op_read  = 2'd1,
    // header plus as many payload words as the count field says
    op_write = 2'd2,
    // header plus two words
    op_ping  = 2'd3
  } opcode_e;

  // layout of word 0 of every message, MSB first
  typedef struct packed {
    opcode_e                  opcode;
    // payload count, only looked at for op_write
    logic [count_width_c-1:0] count;
    // free data that rides along untouched
    logic [tag_width_c-1:0]   tag;
  } header_s;

  // one beat on the serial channel
  typedef struct packed {
    logic [word_width_c-1:0] data;
    // marks word 0 of a message
    logic                    first;
  } flit_s;

endpackage

// File: logic/msg_len_decode.sv
`timescale 1ns/1ns

module msg_len_decode
  #(parameter int max_els_p = 8
  ,localparam int lg_max_els_lp = $clog2(max_els_p)
  )
  (input  link_pkg::header_s        hdr_i
  ,output logic [lg_max_els_lp-1:0] last_idx_o
  );

  // highest index that still falls inside the message buffer
  localparam int max_idx_lp = max_els_p - 1;

  // last index as the opcode asks for it, before any clamping
  // it is as wide as the count field, since op_write can ask for up to 63
  logic [link_pkg::count_width_c-1:0] raw_idx;

  // every opcode but op_write has a fixed length
  // the last index is the number of words after the header
  always_comb
  begin
    raw_idx = '0;
    case (hdr_i.opcode)
      link_pkg::op_nop:
        raw_idx = '0;
      link_pkg::op_read:
        raw_idx = link_pkg::count_width_c'(1);
      link_pkg::op_ping:
        raw_idx = link_pkg::count_width_c'(2);
      link_pkg::op_write:
        raw_idx = hdr_i.count;
    endcase
  end

  // a write that asks for more words than the buffer holds is cut to a full buffer
  // so neither side of the link can index past its last element
  // the clamp also covers op_ping when the buffer has only two words
  // both ends run this same rule, so they always agree on the length
  assign last_idx_o = (int'(raw_idx) > max_idx_lp) ? lg_max_els_lp'(max_idx_lp)
                                                   : lg_max_els_lp'(raw_idx);

endmodule

// File: logic/msg_link_top.sv
`timescale 1ns/1ns

module msg_link_top
  #(parameter int width_p = link_pkg::word_width_c
  ,parameter int max_els_p = link_pkg::max_words_c
  ,localparam int lg_max_els_lp = $clog2(max_els_p)
  ,localparam int lg_nwords_lp = $clog2(max_els_p + 1)
  )
  (input                                      clk_i
  ,input                                      reset_i

  // sender channel, a whole message per handshake
  ,input                                      v_i
  ,input        [max_els_p-1:0][width_p-1:0]  msg_i
  ,output logic                               ready_o

  // rebuilt message with its word count
  ,output logic                               v_o
  ,output logic [max_els_p-1:0][width_p-1:0]  msg_o
  ,output logic [lg_nwords_lp-1:0]            nwords_o
  ,input                                      ready_i
  );

  // serial channel between the two ends
  link_pkg::flit_s          ser_flit;
  logic                     ser_v;
  logic                     ser_ready;

  // each end works out the message length on its own
  logic [lg_max_els_lp-1:0] tx_last_idx;
  logic [lg_max_els_lp-1:0] rx_last_idx;

  // the serializer puts word 0 on the channel while its count is zero,
  // so this decode never looks at v_i
  msg_len_decode #(.max_els_p(max_els_p)) tx_len
    (.hdr_i     (link_pkg::header_s'(ser_flit.data))
    ,.last_idx_o(tx_last_idx)
    );

  piso_passthrough_dynamic #(.width_p(width_p), .max_els_p(max_els_p)) piso
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.v_i        (v_i)
    ,.data_i     (msg_i)
    ,.ready_and_o(ready_o)
    ,.v_o        (ser_v)
    ,.flit_o     (ser_flit)
    ,.len_i      (tx_last_idx)
    ,.ready_and_i(ser_ready)
    );

  // the far end reads the header as it comes off the channel
  msg_len_decode #(.max_els_p(max_els_p)) rx_len
    (.hdr_i     (link_pkg::header_s'(ser_flit.data))
    ,.last_idx_o(rx_last_idx)
    );

  sipo_assembler #(.width_p(width_p), .max_els_p(max_els_p)) sipo
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.v_i        (ser_v)
    ,.flit_i     (ser_flit)
    ,.last_idx_i (rx_last_idx)
    ,.ready_and_o(ser_ready)
    ,.v_o        (v_o)
    ,.msg_o      (msg_o)
    ,.nwords_o   (nwords_o)
    ,.ready_and_i(ready_i)
    );

endmodule

// File: logic/piso_passthrough_dynamic.sv
`timescale 1ns/1ns

// Parallel in, serial out without any storage of the message itself.
// the sender holds the whole message on data_i while the words go out one
// per accepted beat, and only the final beat hands back ready_and_o
// the length of the message is given on the serial side through len_i,
// which is valid together with the first word
module piso_passthrough_dynamic
  #(parameter int width_p = 16
  ,parameter int max_els_p = 8
  ,localparam int lg_max_els_lp = $clog2(max_els_p)
  )
  (input                                      clk_i
  ,input                                      reset_i

  // parallel side, held steady by the sender until ready_and_o
  ,input                                      v_i
  ,input        [max_els_p-1:0][width_p-1:0]  data_i
  ,output logic                               ready_and_o

  // serial side
  ,output logic                               v_o
  ,output link_pkg::flit_s                    flit_o
  ,input        [lg_max_els_lp-1:0]           len_i
  ,input                                      ready_and_i
  );

  // index of the word that is on the serial side right now
  logic [lg_max_els_lp-1:0] count_r;

  // last index of the message in flight, taken from len_i on word 0
  logic [lg_max_els_lp-1:0] len_r;

  // decoded counter states
  logic is_zero_cnt;
  logic is_last_cnt;
  logic is_zero_len;

  // counter and length register controls
  logic len_en;
  logic cnt_up;
  logic cnt_clear;

  // a beat moves whenever the far side is ready and we offer a word
  logic beat;

  // the serial valid is a pure pass of the sender's valid
  // nothing is ever buffered here, so there is nothing else to offer
  assign v_o  = v_i;
  assign beat = v_o & ready_and_i;

  assign is_zero_cnt = (count_r == '0);

  // only a later word can be the last one through len_r
  // a zero length message is handled on word 0 through len_i instead
  assign is_last_cnt = ~is_zero_cnt & (count_r == len_r);

  // header only message, finished in a single beat
  // this looks at len_i only on word 0, where it is valid
  assign is_zero_len = is_zero_cnt & (len_i == '0);

  // ready_and_o only comes back on a beat that is really taken
  // the sender sees it in the same cycle its final word is taken
  assign ready_and_o = beat & (is_last_cnt | is_zero_len);

  // the length is caught on the first accepted beat
  assign len_en = beat & is_zero_cnt;

  // a finished message brings the counter back to word 0
  assign cnt_clear = ready_and_o;

  // otherwise every accepted beat moves on to the next word
  assign cnt_up = beat & ~cnt_clear;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
    end
    else if (cnt_clear)
    begin
      count_r <= '0;
    end
    else if (cnt_up)
    begin
      count_r <= count_r + lg_max_els_lp'(1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      len_r <= '0;
    end
    else if (len_en)
    begin
      len_r <= len_i;
    end
  end

  // the counter picks the word straight out of the held message
  // first marks word 0, which carries the header
  // the counter never runs past len_r, and len_i is already clamped
  // to the buffer, so the select always stays in range
  assign flit_o = '{data: data_i[count_r], first: is_zero_cnt};

endmodule

// File: logic/sipo_assembler.sv
`timescale 1ns/1ns

// Serial in, parallel out.
// serial words are written into a message register as they arrive; once
// the last one is in, the whole message is shown on msg_o with its word
// count and held until the consumer takes it
module sipo_assembler
  #(parameter int width_p = 16
  ,parameter int max_els_p = 8
  ,localparam int lg_max_els_lp = $clog2(max_els_p)
  ,localparam int lg_nwords_lp = $clog2(max_els_p + 1)
  )
  (input                                      clk_i
  ,input                                      reset_i

  // serial side
  ,input                                      v_i
  ,input  link_pkg::flit_s                    flit_i
  ,input        [lg_max_els_lp-1:0]           last_idx_i
  ,output logic                               ready_and_o

  // message side
  ,output logic                               v_o
  ,output logic [max_els_p-1:0][width_p-1:0]  msg_o
  ,output logic [lg_nwords_lp-1:0]            nwords_o
  ,input                                      ready_and_i
  );

  // collect while words come in, hold while a full message waits
  typedef enum logic {
    collect_s,
    hold_s
  } state_e;

  state_e state_r;

  // index of the next word to be written
  logic [lg_max_els_lp-1:0] count_r;

  // last index of the current message, caught from the header
  logic [lg_max_els_lp-1:0] last_r;

  // the message being built, then presented
  logic [max_els_p-1:0][width_p-1:0] msg_r;

  // a serial word is taken this cycle
  logic accept;

  // the held message is taken by the consumer this cycle
  logic taken;

  // index that the word being taken lands on
  logic [lg_max_els_lp-1:0] word_idx;

  // last index that applies to the word being taken
  logic [lg_max_els_lp-1:0] end_idx;

  // the word being taken closes its message
  logic done;

  assign v_o   = (state_r == hold_s);
  assign taken = v_o & ready_and_i;

  // no words come in while a message is held, which stalls the serializer
  // the cycle the consumer takes it, a new header may already come in
  assign ready_and_o = (state_r == collect_s) | taken;
  assign accept      = v_i & ready_and_o;

  // a header always lands on word 0 whatever the counter says,
  // and its length comes straight from the decoder in that same cycle
  assign word_idx = flit_i.first ? '0 : count_r;
  assign end_idx  = flit_i.first ? last_idx_i : last_r;
  assign done     = accept & (word_idx == end_idx);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= collect_s;
      count_r <= '0;
      last_r  <= '0;
    end
    else
    begin
      if (accept & flit_i.first)
      begin
        last_r <= last_idx_i;
      end

      // a closing word ends up in hold, even right after a hand off
      if (done)
      begin
        state_r <= hold_s;
        count_r <= '0;
      end
      else
      begin
        if (taken)
        begin
          state_r <= collect_s;
        end
        if (accept)
        begin
          count_r <= word_idx + lg_max_els_lp'(1);
        end
      end
    end
  end

  // the header wipes the old message so unused words read as zero
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (flit_i.first)
      begin
        msg_r    <= '0;
        msg_r[0] <= flit_i.data;
      end
      else
      begin
        msg_r[count_r] <= flit_i.data;
      end
    end
  end

  assign msg_o = msg_r;

  // the last index counts from zero, so one more gives the word count
  assign nwords_o = lg_nwords_lp'(last_r) + lg_nwords_lp'(1);

endmodule

// File: project.f
logic/link_pkg.sv
logic/msg_len_decode.sv
logic/piso_passthrough_dynamic.sv
logic/sipo_assembler.sv
logic/msg_link_top.sv
tb/clk_gen.sv
tb/msg_link_props.sv
tb/msg_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module msg_link_tb -o msg_link_sim

output=$(./obj_dir/msg_link_sim 2>&1) || true
echo "$output"

if grep -q "NO ERRORS" <<< "$output"
then
  exit 0
fi
exit 1

// File: tb/clk_gen.sv
`timescale 1ns/1ns

module clk_gen
  #(parameter int period_p = 8
  )
  (output logic clk_o
  );

  // the clock starts low, so the first rising edge comes half a period in
  initial
  begin
    clk_o = 1'b0;
  end

  always
  begin
    #(period_p / 2);
    clk_o = ~clk_o;
  end

endmodule

// File: tb/msg_link_props.sv
`timescale 1ns/1ns

module msg_link_props
  #(parameter int data_width_p = 128
  )
  (input                     clk_i
  ,input                     reset_i
  // a ready-and offer that has to be held until it is taken
  ,input                     valid_i
  ,input                     ready_i
  ,input  [data_width_p-1:0] data_i
  // one serial word moving, with its first flag and whether it closes its message
  ,input                     beat_i
  ,input                     first_i
  ,input                     last_i
  );

  // high while the next serial word has to be word 0 of a new message
  logic word0_due_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      word0_due_r <= 1'b1;
    end
    else if (beat_i)
    begin
      word0_due_r <= last_i;
    end
  end

  // an offer that is not taken stays up with the same contents into the next cycle
  hold_until_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && !ready_i |=> valid_i && $stable(data_i))
    else $error("offer dropped or changed before the other side took it");

  // a serial word is flagged first exactly when the word before it closed a message
  first_marks_word0: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_i |-> (first_i == word0_due_r))
    else $error("first flag does not follow the message boundaries on a serial beat");

endmodule

// the sender side holds v_i and the whole message until ready_and_o
bind piso_passthrough_dynamic msg_link_props #(.data_width_p(max_els_p * width_p)) piso_props
  (.clk_i(clk_i), .reset_i(reset_i), .valid_i(v_i), .ready_i(ready_and_o), .data_i(data_i)
  ,.beat_i(v_o & ready_and_i), .first_i(flit_o.first), .last_i(ready_and_o));

// the assembler holds v_o and msg_o until the consumer takes them
bind sipo_assembler msg_link_props #(.data_width_p(max_els_p * width_p)) sipo_props
  (.clk_i(clk_i), .reset_i(reset_i), .valid_i(v_o), .ready_i(ready_and_i), .data_i(msg_o)
  ,.beat_i(v_i & ready_and_o), .first_i(flit_i.first), .last_i(done));

// File: tb/msg_link_tb.sv
`timescale 1ns/1ns

module msg_link_tb;

  localparam int width_c        = link_pkg::word_width_c;
  localparam int els_c          = link_pkg::max_words_c;
  localparam int nwords_bits_c  = $clog2(els_c + 1);
  localparam int msg_bits_c     = els_c * width_c;
  localparam int reset_cycles_c = 4;

  typedef logic [els_c-1:0][width_c-1:0] msg_t;

  // what the output side should show for one message
  typedef struct packed {
    logic [nwords_bits_c-1:0] nwords;
    msg_t                     msg;
  } expect_s;

  // one message to send, its test phase and the idle cycles in front of it
  typedef struct packed {
    logic [2:0] phase;
    logic [1:0] gap;
    msg_t       msg;
  } stim_s;

  // phases 3 and 5 run with random back-pressure on the output
  string phase_names [6] = '{"after_reset", "opcodes", "clamp", "backpressure",
                             "back_to_back", "random"};

  logic                     clk;
  logic                     reset;
  logic                     msg_v;
  msg_t                     msg_in;
  logic                     msg_ready;
  logic                     out_v;
  msg_t                     out_msg;
  logic [nwords_bits_c-1:0] out_nwords;
  logic                     out_ready;

  integer  seed;
  stim_s   stim_q[$];
  msg_t    sent_q[$];
  int      checked_count = 0;
  int      cycle_count = 0;
  int      cycle_limit = 0;
  int      ready_mode = 0;
  int      low_left = 0;
  string   test_name = "reset";

  clk_gen #(.period_p(8)) clk_src (.clk_o(clk));

  msg_link_top #(.width_p(width_c), .max_els_p(els_c)) UUT
    (.clk_i(clk), .reset_i(reset), .v_i(msg_v), .msg_i(msg_in), .ready_o(msg_ready)
    ,.v_o(out_v), .msg_o(out_msg), .nwords_o(out_nwords), .ready_i(out_ready));

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [msg_bits_c-1:0] expected,
                             input logic [msg_bits_c-1:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      stop_with_failure();
    end
  endtask

  // reference model: the opcode fixes the last index, write takes its count,
  // anything past the buffer is cut to a full buffer and unused words read zero
  function automatic expect_s expected_result(input msg_t sent);
    link_pkg::header_s hdr;
    int                last;
    expect_s           result;
    hdr = link_pkg::header_s'(sent[0]);
    case (hdr.opcode)
      link_pkg::op_nop:  last = 0;
      link_pkg::op_read: last = 1;
      link_pkg::op_ping: last = 2;
      default:           last = int'(hdr.count);
    endcase
    if (last > els_c - 1)
      last = els_c - 1;
    result.nwords = nwords_bits_c'(last + 1);
    result.msg = '0;
    for (int i = 0; i <= last; i++)
      result.msg[i] = sent[i];
    return result;
  endfunction

  // payload words depend on tag and index, so a misplaced word shows up
  function automatic msg_t build_msg(input link_pkg::opcode_e op, input int count,
                                     input int tag);
    link_pkg::header_s hdr;
    msg_t              m;
    hdr.opcode = op;
    hdr.count = 6'(count);
    hdr.tag = 8'(tag);
    m[0] = hdr;
    for (int i = 1; i < els_c; i++)
      m[i] = width_c'(32'h5a00 + tag * 32 + i);
    return m;
  endfunction

  // counts up to 9 so that clamped writes also come up now and then
  function automatic msg_t random_msg();
    msg_t m;
    m = build_msg(link_pkg::opcode_e'(2'($random(seed))), int'($unsigned($random(seed)) % 10),
                  int'($unsigned($random(seed)) % 256));
    for (int i = 1; i < els_c; i++)
      m[i] = width_c'($random(seed));
    return m;
  endfunction

  task automatic add_stim(input int phase, input int gap, input msg_t m);
    stim_s s;
    s.phase = 3'(phase);
    s.gap = 2'(gap);
    s.msg = m;
    stim_q.push_back(s);
  endtask

  task automatic build_stimulus();
    add_stim(0, 0, build_msg(link_pkg::op_read, 0, 'h11));
    add_stim(1, 1, build_msg(link_pkg::op_nop, 0, 'h21));
    add_stim(1, 1, build_msg(link_pkg::op_read, 0, 'h22));
    add_stim(1, 1, build_msg(link_pkg::op_ping, 0, 'h23));
    add_stim(1, 1, build_msg(link_pkg::op_write, 0, 'h24));
    add_stim(1, 1, build_msg(link_pkg::op_write, 3, 'h25));
    add_stim(1, 1, build_msg(link_pkg::op_write, 7, 'h26));
    add_stim(2, 1, build_msg(link_pkg::op_write, 9, 'h31));
    add_stim(2, 1, build_msg(link_pkg::op_write, 63, 'h32));
    for (int i = 0; i < 12; i++)
      add_stim(3, 0, random_msg());
    // opcodes cycle through nop, read, write and ping with no idle cycle between
    for (int i = 0; i < 10; i++)
      add_stim(4, 0, build_msg(link_pkg::opcode_e'(2'(i)), i % 8, 'h40 + i));
    for (int i = 0; i < 200; i++)
      add_stim(5, int'($unsigned($random(seed)) % 3), random_msg());
  endtask

  // random mode holds ready low in bursts of 2 to 7 cycles
  task automatic drive_ready();
    if (ready_mode == 0)
      out_ready = 1'b1;
    else if (low_left > 0)
    begin
      out_ready = 1'b0;
      low_left--;
    end
    else if ($unsigned($random(seed)) % 4 == 0)
    begin
      out_ready = 1'b0;
      low_left = 1 + int'($unsigned($random(seed)) % 6);
    end
    else
      out_ready = 1'b1;
  endtask

  // all inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    drive_ready();
  endtask

  task automatic send_msg(input msg_t m);
    expect_s exp;
    int      beats;
    logic    accepted;
    exp = expected_result(m);
    msg_v = 1'b1;
    msg_in = m;
    sent_q.push_back(m);
    beats = 0;
    do
    begin
      beats++;
      @(negedge clk);
      accepted = msg_ready;
      next_cycle();
    end
    while (!accepted);
    msg_v = 1'b0;
    // with the output always taken the link never stalls, one beat per word
    if (ready_mode == 0)
      check_value("accept beats", msg_bits_c'(exp.nwords), msg_bits_c'(beats));
  endtask

  // compares every message that leaves the DUT against the oldest one sent
  initial
  begin
    expect_s exp;
    forever
    begin
      @(negedge clk);
      // the sender channel gives no ready while nothing is offered
      if (!reset && !msg_v)
        check_value("ready_o while idle", '0, msg_bits_c'(msg_ready));
      if (!reset && out_v && out_ready)
      begin
        if (sent_q.size() == 0)
        begin
          $display("a message came out of the link that was never sent");
          stop_with_failure();
        end
        exp = expected_result(sent_q.pop_front());
        check_value("nwords", msg_bits_c'(exp.nwords), msg_bits_c'(out_nwords));
        check_value("msg", exp.msg, out_msg);
        checked_count++;
      end
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
      begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        stop_with_failure();
      end
    end
  end

  initial
  begin
    stim_s   s;
    expect_s exp;
    int      total_words;
    int      total_msgs;
    seed = 53;
    reset = 1'b1;
    msg_v = 1'b0;
    msg_in = '0;
    out_ready = 1'b1;
    build_stimulus();
    total_msgs = stim_q.size();
    total_words = 0;
    foreach (stim_q[i])
    begin
      exp = expected_result(stim_q[i].msg);
      total_words += int'(exp.nwords);
    end
    cycle_limit = (total_words + total_msgs) * 4 + reset_cycles_c + 100;
    repeat (reset_cycles_c) next_cycle();
    reset = 1'b0;
    test_name = phase_names[0];
    @(negedge clk);
    check_value("v_o after reset", '0, msg_bits_c'(out_v));
    next_cycle();
    while (stim_q.size() > 0)
    begin
      s = stim_q.pop_front();
      test_name = phase_names[s.phase];
      ready_mode = (s.phase == 3'd3 || s.phase == 3'd5) ? 1 : 0;
      // a ready-high phase takes effect at once, even with no idle cycle first
      if (ready_mode == 0)
        drive_ready();
      repeat (int'(s.gap)) next_cycle();
      send_msg(s.msg);
    end
    test_name = "drain";
    while (checked_count < total_msgs)
      next_cycle();
    $display("NO ERRORS");
    $finish;
  end

endmodule
